//--- hw/isaPkg.sv
package isaPkg;

	localparam int DataWidth = 32;
	localparam int RegCount = 16;
	localparam int RegIndexWidth = $clog2(RegCount);
	localparam int OpcodeWidth = 5;
	localparam int ShiftBits = 5; // only the low bits of rb count as a shift amount
	localparam int DivSteps = DataWidth; // one quotient bit per cycle

	typedef logic [DataWidth-1:0] dataWord;
	typedef logic [2*DataWidth-1:0] productWord;
	typedef logic [RegIndexWidth-1:0] regIndex;
	typedef logic [ShiftBits-1:0] shiftAmount;
	typedef logic [$clog2(DivSteps)-1:0] divStep;

	typedef enum logic [OpcodeWidth-1:0] {
		ldi, // load the carried word into rd
		add,
		sub,
		andOp,
		orOp,
		notOp,
		neg,
		mul, // HI:LO get the signed product
		div, // LO quotient, HI remainder
		rol,
		ror,
		shl,
		shr,
		shra
	} opcode;

	// division by zero gives all ones, remainder keeps the dividend
	localparam dataWord DivZeroQuotient = '1;

	function automatic logic usesRa(opcode op);
		return op != ldi;
	endfunction

	function automatic logic usesRb(opcode op);
		return !(op inside {ldi, notOp, neg});
	endfunction

	function automatic logic isSingleCycle(opcode op);
		return !(op inside {mul, div}); // the others leave HI alone
	endfunction

endpackage

//--- hw/streamPkg.sv
package streamPkg;

	localparam int InstrQueueDepth = 4; // credits the sender holds after reset
	localparam int QueuePtrWidth = $clog2(InstrQueueDepth);
	localparam int ResultCreditMax = 2; // credits the receiver grants after reset
	localparam int CreditWidth = $clog2(ResultCreditMax + 1);

	typedef logic [QueuePtrWidth-1:0] queuePtr;
	typedef logic [QueuePtrWidth:0] queueCount;
	typedef logic [CreditWidth-1:0] creditCount;

	// instruction as it arrives, already fetched
	typedef struct packed {
		isaPkg::opcode op;
		isaPkg::regIndex rd;
		isaPkg::regIndex ra;
		isaPkg::regIndex rb;
		isaPkg::dataWord data; // only meaningful for ldi
	} instrPacket;

	// decode to execute, operands already read
	typedef struct packed {
		isaPkg::opcode op;
		isaPkg::regIndex rd;
		isaPkg::dataWord aVal;
		isaPkg::dataWord bVal;
	} issuePacket;

	typedef struct packed {
		isaPkg::opcode op;
		isaPkg::regIndex rd;
		isaPkg::dataWord hi; // HI after the instruction
		isaPkg::dataWord lo; // goes to rd and LO
	} resultPacket;

endpackage

//--- hw/registerFile.sv
module registerFile (
	input logic Clock,
	input logic rst,
	input isaPkg::regIndex rdA,
	input isaPkg::regIndex rdB,
	output isaPkg::dataWord aVal,
	output isaPkg::dataWord bVal,
	input logic wrEn,
	input isaPkg::regIndex wrIndex,
	input isaPkg::dataWord wrData,
	input isaPkg::dataWord hiData,
	input isaPkg::dataWord loData,
	input logic hiWr,
	output isaPkg::dataWord hiNow
);
	import isaPkg::*;

	dataWord regs [RegCount];
	dataWord hiReg;
	dataWord loReg; // architectural LO, follows every result

	always_ff @(posedge Clock) begin
		if (rst) begin
			for (int i = 0; i < RegCount; i++) begin
				regs[i] <= '0;
			end
			hiReg <= '0;
			loReg <= '0;
		end else if (wrEn) begin
			regs[wrIndex] <= wrData;
			loReg <= loData;
			if (hiWr) begin
				hiReg <= hiData; // only mul and div touch HI
			end
		end
	end

	// asynchronous reads for decode
	assign aVal = regs[rdA];
	assign bVal = regs[rdB];
	assign hiNow = hiReg;

endmodule

//--- hw/instrDecode.sv
module instrDecode (
	input logic Clock,
	input logic rst,
	input logic instrValid,
	input streamPkg::instrPacket instr,
	output logic instrCredit,
	output isaPkg::regIndex rdA,
	output isaPkg::regIndex rdB,
	input isaPkg::dataWord aVal,
	input isaPkg::dataWord bVal,
	output logic issueValid,
	output streamPkg::issuePacket issue,
	input logic exBusy,
	input logic clearBusy,
	input isaPkg::regIndex clearIndex
);
	import isaPkg::*;
	import streamPkg::*;

	instrPacket instrFifo [InstrQueueDepth];
	queuePtr wrPtr;
	queuePtr rdPtr;
	queueCount count;
	logic [RegCount-1:0] busy; // scoreboard, one bit per general register
	instrPacket head;
	logic srcBusy;
	logic dstBusy;

	assign head = instrFifo[rdPtr];

	// register file is addressed straight from the queue head
	assign rdA = head.ra;
	assign rdB = head.rb;

	assign srcBusy = (usesRa(head.op) && busy[head.ra]) ||
		(usesRb(head.op) && busy[head.rb]);
	assign dstBusy = busy[head.rd]; // keeps results in program order

	// no forwarding, any hazard just stalls the head
	assign issueValid = (count != '0) && !exBusy && !srcBusy && !dstBusy;
	assign instrCredit = issueValid; // one credit back per pop

	always_comb begin
		issue.op = head.op;
		issue.rd = head.rd;
		issue.aVal = (head.op == ldi) ? head.data : aVal; // ldi carries its own word
		issue.bVal = bVal;
	end

	always_ff @(posedge Clock) begin
		if (instrValid) begin
			instrFifo[wrPtr] <= instr; // sender only sends with a credit
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (instrValid) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (issueValid) begin
				rdPtr <= rdPtr + 1'b1;
			end
			count <= count + queueCount'(instrValid) - queueCount'(issueValid);
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			busy <= '0;
		end else begin
			if (clearBusy) begin
				busy[clearIndex] <= 1'b0; // writeback has written it
			end
			if (issueValid) begin
				busy[head.rd] <= 1'b1;
			end
		end
	end

endmodule

//--- hw/aluExecute.sv
module aluExecute (
	input logic Clock,
	input logic rst,
	input logic issueValid,
	input streamPkg::issuePacket issue,
	output logic exBusy,
	output logic doneValid,
	output streamPkg::resultPacket done,
	input logic wbFull,
	input isaPkg::dataWord hiNow
);
	import isaPkg::*;
	import streamPkg::*;

	typedef enum logic [1:0] {idle, mulWait, divRun, hold} exState;

	exState state;
	divStep step;
	resultPacket doneReg;
	logic keepHi; // single-cycle op, report live HI
	dataWord opA; // dividend is kept here for the zero divisor case
	dataWord opB;
	productWord product;
	dataWord quo;
	dataWord rem;
	dataWord divisor;
	logic quoNeg;
	logic remNeg;
	logic divZero;
	logic [DataWidth:0] remShift;
	logic [DataWidth:0] trial;
	dataWord nextQuo;
	dataWord nextRem;
	dataWord finalQuo;
	dataWord finalRem;
	logic lastStep;

	function automatic dataWord aluSingle(opcode op, dataWord a, dataWord b);
		shiftAmount amt;
		productWord rotL;
		productWord rotR;
		amt = b[ShiftBits-1:0];
		rotL = {a, a} << amt;
		rotR = {a, a} >> amt;
		case (op)
			add: return a + b;
			sub: return a - b;
			andOp: return a & b;
			orOp: return a | b;
			notOp: return ~a;
			neg: return -a;
			rol: return rotL[2*DataWidth-1 -: DataWidth];
			ror: return rotR[DataWidth-1:0];
			shl: return a << amt;
			shr: return a >> amt;
			shra: return $signed(a) >>> amt;
			default: return a; // ldi, word already in aVal
		endcase
	endfunction

	// sign extend both sides, low 64 bits of the product are exact
	assign product = {{DataWidth{opA[DataWidth-1]}}, opA} * {{DataWidth{opB[DataWidth-1]}}, opB};

	// restoring shift-subtract on magnitudes
	assign remShift = {rem, quo[DataWidth-1]};
	assign trial = remShift - {1'b0, divisor};
	assign nextRem = trial[DataWidth] ? remShift[DataWidth-1:0] : trial[DataWidth-1:0];
	assign nextQuo = {quo[DataWidth-2:0], ~trial[DataWidth]};
	assign finalQuo = divZero ? DivZeroQuotient : (quoNeg ? -nextQuo : nextQuo);
	assign finalRem = divZero ? opA : (remNeg ? -nextRem : nextRem); // sign follows dividend
	assign lastStep = (step == divStep'(DivSteps - 1));

	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= idle;
			step <= '0;
		end else if (issueValid) begin
			step <= '0;
			if (issue.op == mul) begin
				state <= mulWait;
			end else if (issue.op == div) begin
				state <= divRun;
			end else begin
				state <= hold;
			end
		end else begin
			case (state)
				mulWait: state <= hold;
				divRun: begin
					step <= step + 1'b1;
					if (lastStep) begin
						state <= hold;
					end
				end
				hold: if (!wbFull) state <= idle; // writeback took it this cycle
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if (issueValid) begin
			doneReg.op <= issue.op;
			doneReg.rd <= issue.rd;
			doneReg.lo <= aluSingle(issue.op, issue.aVal, issue.bVal);
			keepHi <= isSingleCycle(issue.op);
			opA <= issue.aVal;
			opB <= issue.bVal;
			quo <= issue.aVal[DataWidth-1] ? -issue.aVal : issue.aVal;
			divisor <= issue.bVal[DataWidth-1] ? -issue.bVal : issue.bVal;
			rem <= '0;
			quoNeg <= issue.aVal[DataWidth-1] ^ issue.bVal[DataWidth-1];
			remNeg <= issue.aVal[DataWidth-1];
			divZero <= (issue.bVal == '0);
		end else if (state == mulWait) begin
			doneReg.hi <= product[2*DataWidth-1 -: DataWidth];
			doneReg.lo <= product[DataWidth-1:0];
		end else if (state == divRun) begin
			quo <= nextQuo;
			rem <= nextRem;
			if (lastStep) begin
				doneReg.hi <= finalRem;
				doneReg.lo <= finalQuo;
			end
		end
	end

	assign doneValid = (state == hold);
	assign exBusy = (state == mulWait) || (state == divRun) || (state == hold && wbFull);

	// HI is sampled when writeback is empty, so earlier results are already in it
	always_comb begin
		done = doneReg;
		if (keepHi) begin
			done.hi = hiNow;
		end
	end

endmodule

//--- hw/resultWriteback.sv
module resultWriteback (
	input logic Clock,
	input logic rst,
	input logic doneValid,
	input streamPkg::resultPacket done,
	output logic wbFull,
	output logic resultValid,
	output streamPkg::resultPacket result,
	input logic resultCredit,
	output logic wrEn,
	output isaPkg::regIndex wrIndex,
	output isaPkg::dataWord wrData,
	output isaPkg::dataWord hiData,
	output isaPkg::dataWord loData,
	output logic hiWr,
	output logic clearBusy,
	output isaPkg::regIndex clearIndex
);
	import isaPkg::*;
	import streamPkg::*;

	resultPacket buffer; // one-entry result buffer
	logic bufValid;
	creditCount credits;
	logic take;

	assign take = doneValid && !bufValid;
	assign wbFull = bufValid; // stays high through the send cycle

	// send as soon as a credit is there
	assign resultValid = bufValid && (credits != '0);
	assign result = buffer;

	// registers are written in the cycle the result leaves
	assign wrEn = resultValid;
	assign wrIndex = buffer.rd;
	assign wrData = buffer.lo;
	assign loData = buffer.lo;
	assign hiData = buffer.hi;
	assign hiWr = !isSingleCycle(buffer.op);

	assign clearBusy = resultValid;
	assign clearIndex = buffer.rd;

	always_ff @(posedge Clock) begin
		if (take) begin
			buffer <= done;
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			bufValid <= 1'b0;
			credits <= creditCount'(ResultCreditMax);
		end else begin
			if (resultValid) begin
				bufValid <= 1'b0;
			end else if (take) begin
				bufValid <= 1'b1;
			end
			// return and spend in one cycle cancel out
			credits <= credits - creditCount'(resultValid) + creditCount'(resultCredit);
		end
	end

endmodule

//--- hw/busDatapath.sv
module busDatapath (
	input logic Clock,
	input logic rst,
	input logic instrValid,
	input streamPkg::instrPacket instr,
	output logic instrCredit,
	output logic resultValid,
	output streamPkg::resultPacket result,
	input logic resultCredit
);
	import isaPkg::*;
	import streamPkg::*;

	regIndex rdA;
	regIndex rdB;
	dataWord aVal;
	dataWord bVal;
	dataWord hiNow;
	logic issueValid;
	issuePacket issue;
	logic exBusy;
	logic doneValid;
	resultPacket done;
	logic wbFull;
	logic wrEn;
	regIndex wrIndex;
	dataWord wrData;
	dataWord hiData;
	dataWord loData;
	logic hiWr;
	logic clearBusy;
	regIndex clearIndex;

	instrDecode decode0 (
		.Clock(Clock),
		.rst(rst),
		.instrValid(instrValid),
		.instr(instr),
		.instrCredit(instrCredit),
		.rdA(rdA),
		.rdB(rdB),
		.aVal(aVal),
		.bVal(bVal),
		.issueValid(issueValid),
		.issue(issue),
		.exBusy(exBusy),
		.clearBusy(clearBusy),
		.clearIndex(clearIndex)
	);

	aluExecute execute0 (
		.Clock(Clock),
		.rst(rst),
		.issueValid(issueValid),
		.issue(issue),
		.exBusy(exBusy),
		.doneValid(doneValid),
		.done(done),
		.wbFull(wbFull),
		.hiNow(hiNow)
	);

	resultWriteback writeback0 (
		.Clock(Clock),
		.rst(rst),
		.doneValid(doneValid),
		.done(done),
		.wbFull(wbFull),
		.resultValid(resultValid),
		.result(result),
		.resultCredit(resultCredit),
		.wrEn(wrEn),
		.wrIndex(wrIndex),
		.wrData(wrData),
		.hiData(hiData),
		.loData(loData),
		.hiWr(hiWr),
		.clearBusy(clearBusy),
		.clearIndex(clearIndex)
	);

	registerFile regFile0 (
		.Clock(Clock),
		.rst(rst),
		.rdA(rdA),
		.rdB(rdB),
		.aVal(aVal),
		.bVal(bVal),
		.wrEn(wrEn),
		.wrIndex(wrIndex),
		.wrData(wrData),
		.hiData(hiData),
		.loData(loData),
		.hiWr(hiWr),
		.hiNow(hiNow)
	);

endmodule

//--- tests/datapath_props.sv
module datapathProps (
	input logic Clock,
	input logic rst,
	input logic instrValid,
	input logic instrCredit,
	input logic resultValid,
	input logic resultCredit
);
	timeunit 1ns;
	timeprecision 100ps;

	import streamPkg::*;

	int resultCredits; // what the DUT may still send
	int queued; // accepted instructions not yet credited back
	int failCount = 0;

	always @(posedge Clock) begin
		if (rst) begin
			resultCredits <= ResultCreditMax;
			queued <= 0;
		end else begin
			resultCredits <= resultCredits - int'(resultValid) + int'(resultCredit);
			queued <= queued + int'(instrValid) - int'(instrCredit);
		end
	end

	sendNeedsCredit: assert property (@(posedge Clock) disable iff (rst)
		resultValid |-> resultCredits > 0)
	else begin
		failCount++;
		$error("resultValid raised with no result credit left");
	end

	creditNeedsInstr: assert property (@(posedge Clock) disable iff (rst)
		instrCredit |-> queued > 0)
	else begin
		failCount++;
		$error("instrCredit returned more credits than instructions accepted");
	end

	// first reset edge still sees unreset state
	quietInReset: assert property (@(posedge Clock)
		rst && $past(rst) |-> !resultValid && !instrCredit)
	else begin
		failCount++;
		$error("resultValid or instrCredit high during reset");
	end

endmodule

bind busDatapath datapathProps props0 (
	.Clock(Clock),
	.rst(rst),
	.instrValid(instrValid),
	.instrCredit(instrCredit),
	.resultValid(resultValid),
	.resultCredit(resultCredit)
);

//--- tests/resultChecker.sv
module resultChecker #(
	parameter int Seed = 1
) (
	input logic Clock,
	input logic rst,
	input logic resultValid,
	input streamPkg::resultPacket result,
	output logic resultCredit,
	output int checkedCount,
	output int passCount,
	output int failCount
);
	timeunit 1ns;
	timeprecision 100ps;

	import isaPkg::*;
	import streamPkg::*;

	localparam int MaxCreditDelay = 5;
	localparam int DriveDelay = 1;

	string expName [$];
	resultPacket expPacket [$];
	int creditDue [$]; // cycle numbers when a credit goes back
	int cycle;

	task automatic addExpected(string name, opcode op, regIndex rd, dataWord hi, dataWord lo);
		resultPacket pkt;
		pkt.op = op;
		pkt.rd = rd;
		pkt.hi = hi;
		pkt.lo = lo;
		expName.push_back(name);
		expPacket.push_back(pkt);
	endtask

	task automatic compareField(string name, string field, dataWord expected, dataWord actual,
			inout logic ok);
		if (expected !== actual) begin
			$display("mismatch %s %s expected %h actual %h", name, field, expected, actual);
			ok = 1'b0;
		end
	endtask

	task automatic checkResult(resultPacket got);
		string name;
		resultPacket want;
		logic ok;
		if (expPacket.size() == 0) begin
			$display("result for r%0d arrived with no test pending", got.rd);
			failCount++;
			return;
		end
		name = expName.pop_front();
		want = expPacket.pop_front(); // results must come back in program order
		ok = 1'b1;
		compareField(name, "op", dataWord'(want.op), dataWord'(got.op), ok);
		compareField(name, "rd", dataWord'(want.rd), dataWord'(got.rd), ok);
		compareField(name, "hi", want.hi, got.hi, ok);
		compareField(name, "lo", want.lo, got.lo, ok);
		checkedCount++;
		if (ok) begin
			passCount++;
			$display("pass %s hi %h lo %h", name, got.hi, got.lo);
		end else begin
			failCount++;
		end
	endtask

	initial begin : creditReturn
		void'($urandom(Seed));
		resultCredit = 1'b0;
		checkedCount = 0;
		passCount = 0;
		failCount = 0;
		cycle = 0;
		forever begin
			@(posedge Clock);
			cycle++;
			if (!rst && resultValid) begin
				checkResult(result);
				creditDue.push_back(cycle + int'($urandom_range(MaxCreditDelay)));
			end
			#DriveDelay;
			// one pulse per cycle, a late head delays the ones behind it
			if (creditDue.size() > 0 && creditDue[0] <= cycle) begin
				void'(creditDue.pop_front());
				resultCredit = 1'b1;
			end else begin
				resultCredit = 1'b0;
			end
		end
	end

endmodule

//--- tests/datapathTb.sv
module datapathTb;
	timeunit 1ns;
	timeprecision 100ps;

	import isaPkg::*;
	import streamPkg::*;

	localparam int ClockPeriod = 10;
	localparam int ResetCycles = 8;
	localparam int DriveDelay = 1;
	localparam int CyclesPerTest = 60;
	localparam int WatchdogSlack = 200;
	localparam int RandomSeed = 36;
	localparam VectorFile = "tests/datapathVectors.txt";

	logic Clock;
	logic rst;
	logic instrValid;
	instrPacket instr;
	logic instrCredit;
	logic resultValid;
	resultPacket result;
	logic resultCredit;
	int checkedCount;
	int passCount;
	int failCount;

	string testName [$];
	instrPacket testInstr [$];
	dataWord testHi [$];
	dataWord testLo [$];
	int numTests;
	logic vectorsReady;

	busDatapath dut0 (
		.Clock(Clock),
		.rst(rst),
		.instrValid(instrValid),
		.instr(instr),
		.instrCredit(instrCredit),
		.resultValid(resultValid),
		.result(result),
		.resultCredit(resultCredit)
	);

	resultChecker #(.Seed(RandomSeed)) resultCheck0 (
		.Clock(Clock),
		.rst(rst),
		.resultValid(resultValid),
		.result(result),
		.resultCredit(resultCredit),
		.checkedCount(checkedCount),
		.passCount(passCount),
		.failCount(failCount)
	);

	initial begin
		Clock = 1'b0;
		forever begin
			#(ClockPeriod / 2) Clock = ~Clock;
		end
	end

	task automatic readVectors(output int count);
		int fd;
		int fields;
		string line;
		string name;
		logic [31:0] opField;
		logic [31:0] rdField;
		logic [31:0] raField;
		logic [31:0] rbField;
		logic [31:0] dataField;
		logic [31:0] hiField;
		logic [31:0] loField;
		instrPacket pkt;
		count = 0;
		fd = $fopen(VectorFile, "r");
		if (fd == 0) begin
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.substr(0, 0) == "#") begin
				continue; // blank or column notes
			end
			fields = $sscanf(line, "%s %h %h %h %h %h %h %h", name, opField, rdField,
				raField, rbField, dataField, hiField, loField);
			if (fields == 8) begin
				pkt.op = opcode'(opField[OpcodeWidth-1:0]);
				pkt.rd = rdField[RegIndexWidth-1:0];
				pkt.ra = raField[RegIndexWidth-1:0];
				pkt.rb = rbField[RegIndexWidth-1:0];
				pkt.data = dataField;
				testName.push_back(name);
				testInstr.push_back(pkt);
				testHi.push_back(hiField);
				testLo.push_back(loField);
				count++;
			end
		end
		$fclose(fd);
	endtask

	initial begin : watchdog
		wait (vectorsReady === 1'b1);
		repeat (numTests * CyclesPerTest + WatchdogSlack) @(posedge Clock);
		$display("timeout: only %0d of %0d results arrived, the rest are missing",
			checkedCount, numTests);
		$display("** FAIL **");
		$finish;
	end

	initial begin : stimulus
		int sent;
		int credits;
		int totalFails;
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		vectorsReady = 1'b0;
		readVectors(numTests);
		vectorsReady = 1'b1;
		repeat (ResetCycles) @(posedge Clock);
		#DriveDelay rst = 1'b0;
		credits = InstrQueueDepth; // the queue is empty after reset
		sent = 0;
		while (sent < numTests) begin
			@(posedge Clock);
			if (instrCredit) begin
				credits++;
			end
			#DriveDelay;
			if (credits > 0) begin
				instr = testInstr[sent];
				instrValid = 1'b1;
				credits--;
				resultCheck0.addExpected(testName[sent], testInstr[sent].op,
					testInstr[sent].rd, testHi[sent], testLo[sent]);
				sent++;
			end else begin
				instrValid = 1'b0; // out of credits, wait for the queue to drain
			end
		end
		@(posedge Clock);
		#DriveDelay instrValid = 1'b0;
		wait (checkedCount >= numTests);
		repeat (20) @(posedge Clock); // catch late extra results
		totalFails = failCount + dut0.props0.failCount;
		if (numTests == 0) begin
			$display("no test vectors could be read from %s", VectorFile);
			totalFails++;
		end
		$display("tests %0d checked %0d passed %0d failed %0d assertion failures %0d",
			numTests, checkedCount, passCount, failCount, dut0.props0.failCount);
		if (totalFails == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- tests/datapathVectors.txt
# name op rd ra rb data expHi expLo, all numbers in hex
# op is the isaPkg opcode number, unused register fields are zero
ldi_r1    00 1 0 0 00000007 00000000 00000007
ldi_r2    00 2 0 0 fffffffd 00000000 fffffffd
ldi_r3    00 3 0 0 12345678 00000000 12345678
ldi_r4    00 4 0 0 0000f0f0 00000000 0000f0f0
add_r5    01 5 1 2 00000000 00000000 00000004
sub_r6    02 6 5 1 00000000 00000000 fffffffd
and_r7    03 7 3 4 00000000 00000000 00005070
or_r8     04 8 7 1 00000000 00000000 00005077
not_r9    05 9 4 0 00000000 00000000 ffff0f0f
neg_r10   06 a 6 0 00000000 00000000 00000003
ldi_r11   00 b 0 0 00000024 00000000 00000024
rol_r12   09 c 3 b 00000000 00000000 23456781
ror_r13   0a d 3 b 00000000 00000000 81234567
shl_r14   0b e 2 b 00000000 00000000 ffffffd0
shr_r15   0c f 2 b 00000000 00000000 0fffffff
shra_r15  0d f 9 b 00000000 00000000 fffff0f0
mul_r5    07 5 2 3 00000000 ffffffff c962fc98
add_r6    01 6 1 1 00000000 ffffffff 0000000e
div_r7    08 7 9 1 00000000 fffffffc ffffdd95
div_r8    08 8 8 2 00000000 00000001 ffffe52e
divz_r9   08 9 3 0 00000000 12345678 ffffffff
add_r10   01 a 9 1 00000000 12345678 00000006

//--- files.f
hw/isaPkg.sv
hw/streamPkg.sv
hw/registerFile.sv
hw/instrDecode.sv
hw/aluExecute.sv
hw/resultWriteback.sv
hw/busDatapath.sv
tests/datapath_props.sv
tests/resultChecker.sv
tests/datapathTb.sv
